// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module vga_mouse_tb -f vga_mouse.f --Mdir obj_dir -o vga_mouse_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/vga_mouse_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$log"; then
  exit 1
fi
exit 0

// ==== source/draw_background.sv ====
`timescale 1ns/10ps
`default_nettype none

module draw_background #(
  parameter int h_active = 1024,
  parameter int v_active = 768
) (
  input  logic pclk,
  input  logic reset,
  vga_if.snk   in_vga,
  vga_if.src   out_vga
);

  localparam vga_pkg::coord_t h_last = vga_pkg::coord_t'(h_active - 1);
  localparam vga_pkg::coord_t v_last = vga_pkg::coord_t'(v_active - 1);

  logic on_border;

  assign on_border = (in_vga.hcount == '0) || (in_vga.hcount == h_last) ||
                     (in_vga.vcount == '0) || (in_vga.vcount == v_last);

  always_ff @(posedge pclk) begin
    if (reset) begin
      out_vga.hcount <= '0;
      out_vga.vcount <= '0;
      out_vga.hsync  <= 1'b1;
      out_vga.vsync  <= 1'b1;
      out_vga.hblnk  <= 1'b0;
      out_vga.vblnk  <= 1'b0;
      out_vga.rgb    <= vga_pkg::color_blank;
    end else begin
      out_vga.hcount <= in_vga.hcount;
      out_vga.vcount <= in_vga.vcount;
      out_vga.hsync  <= in_vga.hsync;
      out_vga.vsync  <= in_vga.vsync;
      out_vga.hblnk  <= in_vga.hblnk;
      out_vga.vblnk  <= in_vga.vblnk;
      if (in_vga.hblnk || in_vga.vblnk) begin
        out_vga.rgb <= vga_pkg::color_blank;
      end else if (on_border) begin
        out_vga.rgb <= vga_pkg::color_border;
      end else begin
        // coordinate gradient, 4 pixels per step
        out_vga.rgb <= '{r: in_vga.hcount[5:2], g: in_vga.vcount[5:2], b: vga_pkg::bg_blue};
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/draw_cursor.sv ====
`timescale 1ns/10ps
`default_nettype none

module draw_cursor (
  input  logic                     pclk,
  input  logic                     reset,
  vga_if.snk                       in_vga,
  input  mouse_pkg::mouse_state_t  mouse_state,
  output logic                     hs,
  output logic                     vs,
  output vga_pkg::rgb_t            rgb
);

  mouse_pkg::mouse_state_t cursor_q;
  logic                    vblnk_prev;
  logic                    in_square;
  logic                    active;
  vga_pkg::rgb_t           cursor_color;

  // position changes only between frames, so no tearing
  always_ff @(posedge pclk) begin
    if (reset) begin
      vblnk_prev <= 1'b0;
      cursor_q   <= '0;
    end else begin
      vblnk_prev <= in_vga.vblnk;
      if (in_vga.vblnk && !vblnk_prev) begin
        cursor_q <= mouse_state;
      end
    end
  end

  assign active    = !in_vga.hblnk && !in_vga.vblnk;
  assign in_square = (in_vga.hcount >= cursor_q.x) &&
                     (in_vga.hcount < cursor_q.x + vga_pkg::cursor_size) &&
                     (in_vga.vcount >= cursor_q.y) &&
                     (in_vga.vcount < cursor_q.y + vga_pkg::cursor_size);

  assign cursor_color = cursor_q.left ? vga_pkg::color_cursor_down : vga_pkg::color_cursor_up;

  always_ff @(posedge pclk) begin
    if (reset) begin
      hs  <= 1'b1;
      vs  <= 1'b1;
      rgb <= vga_pkg::color_blank;
    end else begin
      hs <= in_vga.hsync;
      vs <= in_vga.vsync;
      if (active && in_square) begin
        rgb <= cursor_color;
      end else begin
        rgb <= in_vga.rgb;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/mouse_pkg.sv ====
`default_nettype none

package mouse_pkg;

  // one byte as received from the mouse
  typedef logic [7:0] ps2_byte_t;

  // bit positions in the first byte of a packet
  localparam int left_bit   = 0;
  localparam int sync_bit   = 3;
  localparam int x_sign_bit = 4;
  localparam int y_sign_bit = 5;
  localparam int x_ovf_bit  = 6;
  localparam int y_ovf_bit  = 7;

  // cursor position and button, 25 bits
  typedef struct packed {
    vga_pkg::coord_t x;
    vga_pkg::coord_t y;
    logic            left;
  } mouse_state_t;

endpackage

`default_nettype wire

// ==== source/mouse_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

module mouse_tracker #(
  parameter int h_active = 1024,
  parameter int v_active = 768
) (
  input  logic                     pclk,
  input  logic                     reset,
  input  mouse_pkg::ps2_byte_t     rx_byte,
  input  logic                     byte_valid,
  input  logic                     frame_error,
  output mouse_pkg::mouse_state_t  mouse_state
);

  logic [1:0]           byte_cnt;
  mouse_pkg::ps2_byte_t status_q;
  mouse_pkg::ps2_byte_t dx_q;
  logic signed [13:0]   dx_ext;
  logic signed [13:0]   dy_ext;
  logic signed [13:0]   x_sum;
  logic signed [13:0]   y_sum;

  function automatic vga_pkg::coord_t clamp_axis(input logic signed [13:0] pos, input int limit);
    if (pos < 0) begin
      return '0;
    end else if (pos > limit - 1) begin
      return vga_pkg::coord_t'(limit - 1);
    end
    return vga_pkg::coord_t'(pos);
  endfunction

  // 9-bit two's complement moves, dy comes with the third byte
  assign dx_ext = {{6{status_q[mouse_pkg::x_sign_bit]}}, dx_q};
  assign dy_ext = {{6{status_q[mouse_pkg::y_sign_bit]}}, rx_byte};
  assign x_sum  = $signed({2'b00, mouse_state.x}) + dx_ext;
  // screen y grows downwards
  assign y_sum  = $signed({2'b00, mouse_state.y}) - dy_ext;

  always_ff @(posedge pclk) begin
    if (reset) begin
      byte_cnt    <= '0;
      mouse_state <= '0;
    end else if (frame_error) begin
      byte_cnt <= '0;
    end else if (byte_valid) begin
      case (byte_cnt)
        2'd0: begin
          // resync on a status byte
          if (rx_byte[mouse_pkg::sync_bit]) begin
            byte_cnt <= 2'd1;
          end
        end
        2'd1: byte_cnt <= 2'd2;
        default: begin
          byte_cnt         <= '0;
          mouse_state.left <= status_q[mouse_pkg::left_bit];
          if (!status_q[mouse_pkg::x_ovf_bit]) begin
            mouse_state.x <= clamp_axis(x_sum, h_active);
          end
          if (!status_q[mouse_pkg::y_ovf_bit]) begin
            mouse_state.y <= clamp_axis(y_sum, v_active);
          end
        end
      endcase
    end
  end

  always_ff @(posedge pclk) begin
    if (byte_valid && byte_cnt == 2'd0) begin
      status_q <= rx_byte;
    end
    if (byte_valid && byte_cnt == 2'd1) begin
      dx_q <= rx_byte;
    end
  end

  position_on_screen: assert property (
    @(posedge pclk) disable iff (reset)
    (mouse_state.x < h_active) && (mouse_state.y < v_active)
  );

endmodule

`default_nettype wire

// ==== source/ps2_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module ps2_rx #(
  parameter int rx_timeout = 10000
) (
  input  logic                  pclk,
  input  logic                  reset,
  input  logic                  ps2_clk,
  input  logic                  ps2_data,
  output mouse_pkg::ps2_byte_t  rx_byte,
  output logic                  byte_valid,
  output logic                  frame_error
);

  localparam int gap_w = $clog2(rx_timeout + 1);

  typedef enum logic [1:0] {st_idle, st_data, st_parity, st_stop} state_t;

  state_t               state;
  logic [1:0]           clk_sync;
  logic [1:0]           data_sync;
  logic                 clk_prev;
  logic                 clk_fall;
  logic                 data_bit;
  logic [2:0]           bit_cnt;
  logic                 parity_ok;
  logic [gap_w-1:0]     gap_cnt;
  logic                 gap_expired;
  mouse_pkg::ps2_byte_t shift_reg;

  // two-flop synchronizers, idle bus is high
  always_ff @(posedge pclk) begin
    if (reset) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign clk_fall    = clk_prev & ~clk_sync[1];
  assign data_bit    = data_sync[1];
  assign gap_expired = (gap_cnt == gap_w'(rx_timeout - 1));

  always_ff @(posedge pclk) begin
    if (reset) begin
      state       <= st_idle;
      bit_cnt     <= '0;
      parity_ok   <= 1'b0;
      gap_cnt     <= '0;
      byte_valid  <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      byte_valid  <= 1'b0;
      frame_error <= 1'b0;
      // time since the last falling edge inside a frame
      if (clk_fall) begin
        gap_cnt <= '0;
      end else if (state != st_idle) begin
        gap_cnt <= gap_cnt + 1'b1;
      end
      if (clk_fall) begin
        case (state)
          st_idle: begin
            if (!data_bit) begin
              state   <= st_data;
              bit_cnt <= '0;
            end else begin
              frame_error <= 1'b1;
            end
          end
          st_data: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= st_parity;
            end
          end
          st_parity: begin
            // odd parity over data and parity bit
            parity_ok <= ^{shift_reg, data_bit};
            state     <= st_stop;
          end
          default: begin
            if (data_bit && parity_ok) begin
              byte_valid <= 1'b1;
            end else begin
              frame_error <= 1'b1;
            end
            state <= st_idle;
          end
        endcase
      end else if (state != st_idle && gap_expired) begin
        // stalled frame, drop it silently
        state <= st_idle;
      end
    end
  end

  // data arrives lsb first
  always_ff @(posedge pclk) begin
    if (clk_fall && state == st_data) begin
      shift_reg <= {data_bit, shift_reg[7:1]};
    end
    if (clk_fall && state == st_stop) begin
      rx_byte <= shift_reg;
    end
  end

  one_strobe_at_a_time: assert property (
    @(posedge pclk) disable iff (reset) !(byte_valid && frame_error)
  );

endmodule

`default_nettype wire

// ==== source/vga_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface vga_if;

  vga_pkg::coord_t hcount;
  vga_pkg::coord_t vcount;
  // syncs are active low, blanks active high
  logic            hsync;
  logic            vsync;
  logic            hblnk;
  logic            vblnk;
  vga_pkg::rgb_t   rgb;

  modport src (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  modport snk (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

`default_nettype wire

// ==== source/vga_mouse_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_mouse_top #(
  parameter int h_active   = 1024,
  parameter int h_front    = 24,
  parameter int h_sync     = 136,
  parameter int h_back     = 160,
  parameter int v_active   = 768,
  parameter int v_front    = 3,
  parameter int v_sync     = 6,
  parameter int v_back     = 29,
  parameter int rx_timeout = 10000
) (
  input  logic       pclk,
  input  logic       reset,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       hs,
  output logic       vs,
  output logic [3:0] r,
  output logic [3:0] g,
  output logic [3:0] b
);

  mouse_pkg::ps2_byte_t    rx_byte;
  logic                    byte_valid;
  logic                    frame_error;
  mouse_pkg::mouse_state_t mouse_state;
  vga_pkg::rgb_t           rgb;

  // timing to background, background to cursor
  vga_if timing_bus ();
  vga_if bg_bus ();

  vga_timing #(
    .h_active (h_active),
    .h_front  (h_front),
    .h_sync   (h_sync),
    .h_back   (h_back),
    .v_active (v_active),
    .v_front  (v_front),
    .v_sync   (v_sync),
    .v_back   (v_back)
  ) vga_timing_i (
    .pclk  (pclk),
    .reset (reset),
    .vga   (timing_bus.src)
  );

  draw_background #(
    .h_active (h_active),
    .v_active (v_active)
  ) draw_background_i (
    .pclk    (pclk),
    .reset   (reset),
    .in_vga  (timing_bus.snk),
    .out_vga (bg_bus.src)
  );

  ps2_rx #(
    .rx_timeout (rx_timeout)
  ) ps2_rx_i (
    .pclk        (pclk),
    .reset       (reset),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .rx_byte     (rx_byte),
    .byte_valid  (byte_valid),
    .frame_error (frame_error)
  );

  mouse_tracker #(
    .h_active (h_active),
    .v_active (v_active)
  ) mouse_tracker_i (
    .pclk        (pclk),
    .reset       (reset),
    .rx_byte     (rx_byte),
    .byte_valid  (byte_valid),
    .frame_error (frame_error),
    .mouse_state (mouse_state)
  );

  draw_cursor draw_cursor_i (
    .pclk        (pclk),
    .reset       (reset),
    .in_vga      (bg_bus.snk),
    .mouse_state (mouse_state),
    .hs          (hs),
    .vs          (vs),
    .rgb         (rgb)
  );

  assign r = rgb.r;
  assign g = rgb.g;
  assign b = rgb.b;

endmodule

`default_nettype wire

// ==== source/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

  // pixel or line position
  typedef logic [11:0] coord_t;

  // 4 bits per channel, red in the top nibble
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // edge of the active area
  localparam rgb_t color_border = rgb_t'(12'hfff);

  // driven during blanking
  localparam rgb_t color_blank = rgb_t'(12'h000);

  // cursor with left button released
  localparam rgb_t color_cursor_up = rgb_t'(12'hf00);

  // cursor with left button held
  localparam rgb_t color_cursor_down = rgb_t'(12'h0f0);

  // side of the cursor square in pixels
  localparam int cursor_size = 8;

  // fixed blue nibble of the background
  localparam logic [3:0] bg_blue = 4'h8;

endpackage

`default_nettype wire

// ==== source/vga_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_timing #(
  parameter int h_active = 1024,
  parameter int h_front  = 24,
  parameter int h_sync   = 136,
  parameter int h_back   = 160,
  parameter int v_active = 768,
  parameter int v_front  = 3,
  parameter int v_sync   = 6,
  parameter int v_back   = 29
) (
  input  logic pclk,
  input  logic reset,
  vga_if.src   vga
);

  localparam vga_pkg::coord_t h_last       = vga_pkg::coord_t'(h_active + h_front + h_sync + h_back - 1);
  localparam vga_pkg::coord_t v_last       = vga_pkg::coord_t'(v_active + v_front + v_sync + v_back - 1);
  localparam vga_pkg::coord_t h_blank_beg  = vga_pkg::coord_t'(h_active);
  localparam vga_pkg::coord_t v_blank_beg  = vga_pkg::coord_t'(v_active);
  localparam vga_pkg::coord_t h_sync_beg   = vga_pkg::coord_t'(h_active + h_front);
  localparam vga_pkg::coord_t h_sync_end   = vga_pkg::coord_t'(h_active + h_front + h_sync);
  localparam vga_pkg::coord_t v_sync_beg   = vga_pkg::coord_t'(v_active + v_front);
  localparam vga_pkg::coord_t v_sync_end   = vga_pkg::coord_t'(v_active + v_front + v_sync);

  vga_pkg::coord_t hcount_nxt;
  vga_pkg::coord_t vcount_nxt;

  // wrap at the end of each line and frame
  always_comb begin
    hcount_nxt = vga.hcount + 1'b1;
    vcount_nxt = vga.vcount;
    if (vga.hcount == h_last) begin
      hcount_nxt = '0;
      if (vga.vcount == v_last) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vga.vcount + 1'b1;
      end
    end
  end

  // syncs and blanks follow the counter value they travel with
  always_ff @(posedge pclk) begin
    if (reset) begin
      vga.hcount <= '0;
      vga.vcount <= '0;
      vga.hsync  <= 1'b1;
      vga.vsync  <= 1'b1;
      vga.hblnk  <= 1'b0;
      vga.vblnk  <= 1'b0;
    end else begin
      vga.hcount <= hcount_nxt;
      vga.vcount <= vcount_nxt;
      vga.hblnk  <= (hcount_nxt >= h_blank_beg);
      vga.vblnk  <= (vcount_nxt >= v_blank_beg);
      vga.hsync  <= !((hcount_nxt >= h_sync_beg) && (hcount_nxt < h_sync_end));
      vga.vsync  <= !((vcount_nxt >= v_sync_beg) && (vcount_nxt < v_sync_end));
    end
  end

  // colour is filled in by the next stage
  assign vga.rgb = vga_pkg::color_blank;

  // horizontal sync pulse lies inside the horizontal blank
  hsync_in_hblank: assert property (
    @(posedge pclk) disable iff (reset) !vga.hsync |-> vga.hblnk
  );

endmodule

`default_nettype wire

// ==== tb/vga_mouse_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_mouse_tb;

  localparam int h_active     = 32;
  localparam int h_front      = 4;
  localparam int h_sync       = 4;
  localparam int h_back       = 4;
  localparam int v_active     = 24;
  localparam int v_front      = 2;
  localparam int v_sync       = 2;
  localparam int v_back       = 2;
  localparam int h_total      = h_active + h_front + h_sync + h_back;
  localparam int v_total      = v_active + v_front + v_sync + v_back;
  localparam int frame_cycles = h_total * v_total;
  localparam int cursor_side  = 8;
  localparam int n_fixed      = 9;
  localparam int n_rows       = 12;
  // each row needs a packet plus at most three frames, the first scan counts as a row
  localparam int max_cycles   = (n_rows + 1) * 4 * frame_cycles + 1000;

  logic       pclk;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       hs;
  logic       vs;
  logic [3:0] r;
  logic [3:0] g;
  logic [3:0] b;

  // stimulus and expected cursor state per packet
  int   dx_tab[n_rows];
  int   dy_tab[n_rows];
  logic left_tab[n_rows];
  logic bad_par_tab[n_rows];
  logic no_sync_tab[n_rows];
  int   exp_x[n_rows];
  int   exp_y[n_rows];
  logic exp_left[n_rows];

  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  logic [31:0] lfsr_state;

  vga_mouse_top #(
    .h_active   (h_active),
    .h_front    (h_front),
    .h_sync     (h_sync),
    .h_back     (h_back),
    .v_active   (v_active),
    .v_front    (v_front),
    .v_sync     (v_sync),
    .v_back     (v_back),
    .rx_timeout (200)
  ) vga_mouse_top_i (
    .pclk     (pclk),
    .reset    (reset),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .hs       (hs),
    .vs       (vs),
    .r        (r),
    .g        (g),
    .b        (b)
  );

  always #50 pclk = ~pclk;

  always @(posedge pclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("run timed out after %0d cycles without finishing the table", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int clamp_pos(input int pos, input int limit);
    if (pos < 0) begin
      return 0;
    end
    if (pos > limit - 1) begin
      return limit - 1;
    end
    return pos;
  endfunction

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val[k] = lfsr_state[0];
    end
  endtask

  // expected colour of one output pixel
  function automatic logic [11:0] pixel_color(input int h, input int v, input int cx,
                                              input int cy, input logic cl);
    if (h >= h_active || v >= v_active) begin
      return 12'h000;
    end
    if (h >= cx && h < cx + cursor_side && v >= cy && v < cy + cursor_side) begin
      return cl ? 12'h0f0 : 12'hf00;
    end
    if (h == 0 || h == h_active - 1 || v == 0 || v == v_active - 1) begin
      return 12'hfff;
    end
    return {4'((h >> 2) & 15), 4'((v >> 2) & 15), 4'h8};
  endfunction

  task automatic set_row(input int i, input int dx, input int dy, input logic left,
                         input logic bad_par, input logic no_sync, input int ex,
                         input int ey, input logic el);
    dx_tab[i]      = dx;
    dy_tab[i]      = dy;
    left_tab[i]    = left;
    bad_par_tab[i] = bad_par;
    no_sync_tab[i] = no_sync;
    exp_x[i]       = ex;
    exp_y[i]       = ey;
    exp_left[i]    = el;
  endtask

  task automatic fill_table();
    // cursor starts at (0,0), positive dy moves up the screen
    set_row(0, 5, -3, 0, 0, 0, 5, 3, 0);
    set_row(1, 10, -6, 1, 0, 0, 15, 9, 1);
    set_row(2, -4, 2, 0, 0, 0, 11, 7, 0);
    set_row(3, 200, -200, 0, 0, 0, 31, 23, 0);
    set_row(4, -100, 100, 0, 0, 0, 0, 0, 0);
    // parity broken on the dy byte, whole packet dropped
    set_row(5, 7, -5, 1, 1, 0, 0, 0, 0);
    set_row(6, 6, -4, 0, 0, 0, 6, 4, 0);
    // no sync bit; dx and dy bytes have bit 3 clear so none of them starts a packet
    set_row(7, 3, -9, 1, 0, 1, 6, 4, 0);
    set_row(8, 2, 1, 0, 0, 0, 8, 3, 0);
  endtask

  // small signed moves in -8..7
  task automatic fill_random_rows();
    logic [7:0] bits;
    int         dx;
    int         dy;
    int         px;
    int         py;
    logic       left;
    px = exp_x[n_fixed-1];
    py = exp_y[n_fixed-1];
    for (int i = n_fixed; i < n_rows; i++) begin
      take_bits(4, bits);
      dx = bits[3] ? int'(bits[3:0]) - 16 : int'(bits[3:0]);
      take_bits(4, bits);
      dy = bits[3] ? int'(bits[3:0]) - 16 : int'(bits[3:0]);
      take_bits(1, bits);
      left = bits[0];
      px = clamp_pos(px + dx, h_active);
      py = clamp_pos(py - dy, v_active);
      set_row(i, dx, dy, left, 1'b0, 1'b0, px, py, left);
    end
  endtask

  // start, 8 data bits lsb first, odd parity, stop
  task automatic send_ps2_byte(input logic [7:0] data, input logic bad_par);
    logic [10:0] frame;
    logic        parity;
    parity = ~(^data) ^ bad_par;
    frame  = {1'b1, parity, data, 1'b0};
    for (int k = 0; k < 11; k++) begin
      ps2_data = frame[k];
      repeat (4) @(negedge pclk);
      ps2_clk = 1'b0;
      repeat (4) @(negedge pclk);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (8) @(negedge pclk);
  endtask

  task automatic send_packet(input int i);
    logic [8:0] dx9;
    logic [8:0] dy9;
    logic [7:0] status;
    dx9    = 9'(dx_tab[i]);
    dy9    = 9'(dy_tab[i]);
    status = {2'b00, dy9[8], dx9[8], !no_sync_tab[i], 2'b00, left_tab[i]};
    send_ps2_byte(status, 1'b0);
    send_ps2_byte(dx9[7:0], 1'b0);
    send_ps2_byte(dy9[7:0], bad_par_tab[i]);
  endtask

  task automatic wait_vs_fall();
    logic prev;
    prev = vs;
    @(negedge pclk);
    while (!(prev && !vs)) begin
      prev = vs;
      @(negedge pclk);
    end
  endtask

  task automatic scan_frame(input int cx, input int cy, input logic cl);
    int          h;
    int          v;
    logic [11:0] want;
    logic        hs_want;
    logic        vs_want;
    wait_vs_fall();
    // sample at the vs edge shows the first line of the sync pulse
    h = 0;
    v = v_active + v_front;
    for (int n = 0; n < frame_cycles; n++) begin
      hs_want = !(h >= h_active + h_front && h < h_active + h_front + h_sync);
      vs_want = !(v >= v_active + v_front && v < v_active + v_front + v_sync);
      want    = pixel_color(h, v, cx, cy, cl);
      check_count++;
      assert (hs == hs_want && vs == vs_want) else begin
        error_count++;
        $display("[FAIL] %0d ns: sync at (%0d,%0d) is hs %b vs %b, expected hs %b vs %b",
                 $time, h, v, hs, vs, hs_want, vs_want);
      end
      assert ({r, g, b} == want) else begin
        error_count++;
        $display("[FAIL] %0d ns: pixel (%0d,%0d) is %h, expected %h",
                 $time, h, v, {r, g, b}, want);
      end
      h++;
      if (h == h_total) begin
        h = 0;
        v = (v == v_total - 1) ? 0 : v + 1;
      end
      @(negedge pclk);
    end
  endtask

  initial begin
    pclk       = 1'b0;
    reset      = 1'b1;
    ps2_clk    = 1'b1;
    ps2_data   = 1'b1;
    lfsr_state = 32'h978b;
    fill_table();
    fill_random_rows();
    repeat (2) @(negedge pclk);
    reset = 1'b0;
    assert (hs && vs && {r, g, b} == 12'h000) else begin
      error_count++;
      $display("[FAIL] %0d ns: outputs after reset hs %b vs %b rgb %h",
               $time, hs, vs, {r, g, b});
    end
    // home position in red before any packet
    scan_frame(0, 0, 1'b0);
    for (int i = 0; i < n_rows; i++) begin
      send_packet(i);
      wait_vs_fall();
      scan_frame(exp_x[i], exp_y[i], exp_left[i]);
    end
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vga_mouse.f ====
source/vga_pkg.sv
source/mouse_pkg.sv
source/vga_if.sv
source/vga_timing.sv
source/draw_background.sv
source/ps2_rx.sv
source/mouse_tracker.sv
source/draw_cursor.sv
source/vga_mouse_top.sv
tb/vga_mouse_tb.sv
